// File: all.f
+incdir+design
+incdir+test
design/rob_pkg.sv
design/dispatch_unit.sv
design/exec_station.sv
design/reorder_buffer.sv
design/ooo_core.sv
test/tb_ooo_core.sv

// File: design/dispatch_unit.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module dispatch_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     instr_valid_i,
	input  rob_pkg::op_t             instr_op_i,
	input  logic [`NUM_STATIONS-1:0] station_busy_i,
	input  logic                     rob_full_i,
	input  logic                     flush_i,
	output logic                     instr_deq_o,
	output logic [`NUM_STATIONS-1:0] station_load_o,
	output logic [15:0]              dispatch_count_o
);

	logic [`NUM_STATIONS-1:0] pick;
	logic                     found;
	logic                     op_legal;
	logic                     accept;

	// priority search, lowest index wins
	always_comb begin
		pick  = '0;
		found = 1'b0;
		for (int i = 0; i < `NUM_STATIONS; i++) begin
			if (!station_busy_i[i] && !found) begin
				pick[i] = 1'b1;
				found   = 1'b1;
			end
		end
	end

	// undefined opcodes stay in the queue
	always_comb begin
		case (instr_op_i)
			rob_pkg::op_add, rob_pkg::op_sub, rob_pkg::op_mul,
			rob_pkg::op_beq, rob_pkg::op_bne: op_legal = 1'b1;
			default:                          op_legal = 1'b0;
		endcase
	end

	assign accept = instr_valid_i && found && !rob_full_i && !flush_i && op_legal;

	assign instr_deq_o    = accept;
	assign station_load_o = accept ? pick : '0;

	// running count of issued instructions
	always_ff @(posedge clk) begin
		if (rst) begin
			dispatch_count_o <= '0;
		end else if (accept) begin
			dispatch_count_o <= dispatch_count_o + 16'd1;
		end
	end

endmodule

// File: design/exec_station.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module exec_station (
	input  logic               clk,
	input  logic               rst,
	input  logic               flush_i,
	input  logic               load_i,
	input  rob_pkg::op_t       op_i,
	input  logic [`TAG_W-1:0]  tag_i,
	input  logic [`DATA_W-1:0] a_i,
	input  logic [`DATA_W-1:0] b_i,
	output logic               busy_o,
	output logic               done_o,
	output logic [`TAG_W-1:0]  done_tag_o,
	output logic [`DATA_W-1:0] done_data_o
);

	rob_pkg::station_state_t state;
	logic [1:0]              cnt;
	rob_pkg::op_t            op_q;
	logic [`TAG_W-1:0]       tag_q;
	logic [`DATA_W-1:0]      a_q;
	logic [`DATA_W-1:0]      b_q;
	logic [`DATA_W-1:0]      acc;
	logic [`DATA_W-1:0]      alu_result;
	logic [`DATA_W-1:0]      mul_sum;
	logic                    finish;

	always_comb begin
		case (op_q)
			rob_pkg::op_add: alu_result = a_q + b_q;
			rob_pkg::op_sub: alu_result = a_q - b_q;
			rob_pkg::op_beq: alu_result = {{(`DATA_W-1){1'b0}}, a_q == b_q};
			rob_pkg::op_bne: alu_result = {{(`DATA_W-1){1'b0}}, a_q != b_q};
			default:         alu_result = '0;
		endcase
	end

	// a_q is pre-shifted, so each partial product lands in place
	assign mul_sum = acc + a_q * {{(`DATA_W-8){1'b0}}, b_q[7:0]};
	assign finish  = (state == rob_pkg::st_single) ||
	                 (state == rob_pkg::st_mul && cnt == 2'd3);
	assign busy_o  = (state != rob_pkg::st_idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= rob_pkg::st_idle;
			cnt    <= 2'd0;
			done_o <= 1'b0;
		end else if (flush_i) begin
			// work in flight is dropped without a done
			state  <= rob_pkg::st_idle;
			done_o <= 1'b0;
		end else begin
			done_o <= finish;
			case (state)
				rob_pkg::st_idle: begin
					cnt <= 2'd0;
					if (load_i && op_i == rob_pkg::op_mul) begin
						state <= rob_pkg::st_mul;
					end else if (load_i) begin
						state <= rob_pkg::st_single;
					end
				end
				rob_pkg::st_single: state <= rob_pkg::st_idle;
				rob_pkg::st_mul: begin
					cnt <= cnt + 2'd1;
					if (cnt == 2'd3) begin
						state <= rob_pkg::st_idle;
					end
				end
				default: state <= rob_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			op_q  <= op_i;
			tag_q <= tag_i;
			a_q   <= a_i;
			b_q   <= b_i;
			acc   <= '0;
		end else if (state == rob_pkg::st_mul) begin
			acc <= mul_sum;
			a_q <= a_q << 8;
			b_q <= b_q >> 8;
		end
		if (finish) begin
			done_tag_o  <= tag_q;
			done_data_o <= (state == rob_pkg::st_mul) ? mul_sum : alu_result;
		end
	end

endmodule

// File: design/ooo_core.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module ooo_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               instr_valid_i,
	input  logic [`DATA_W-1:0] instr_pc_i,
	input  rob_pkg::op_t       instr_op_i,
	input  logic [4:0]         instr_rd_i,
	input  logic [`DATA_W-1:0] instr_a_i,
	input  logic [`DATA_W-1:0] instr_b_i,
	input  logic               instr_pred_taken_i,
	input  logic [`DATA_W-1:0] instr_target_i,
	output logic               instr_deq_o,
	output logic               commit_valid_o,
	output logic [`DATA_W-1:0] commit_pc_o,
	output logic [4:0]         commit_rd_o,
	output logic [`DATA_W-1:0] commit_data_o,
	output logic               flush_o,
	output logic [`DATA_W-1:0] flush_pc_o,
	output logic [15:0]        issued_count_o
);

	logic [`NUM_STATIONS-1:0] station_busy;
	logic [`NUM_STATIONS-1:0] station_load;
	logic [`NUM_STATIONS-1:0] station_done;
	logic [`TAG_W-1:0]        done_tag  [`NUM_STATIONS];
	logic [`DATA_W-1:0]       done_data [`NUM_STATIONS];
	logic [`TAG_W-1:0]        alloc_tag;
	logic                     rob_full;
	logic                     is_branch;

	assign is_branch = (instr_op_i == rob_pkg::op_beq) || (instr_op_i == rob_pkg::op_bne);

	dispatch_unit i_dispatch_unit (
		.clk              (clk),
		.rst              (rst),
		.instr_valid_i    (instr_valid_i),
		.instr_op_i       (instr_op_i),
		.station_busy_i   (station_busy),
		.rob_full_i       (rob_full),
		.flush_i          (flush_o),
		.instr_deq_o      (instr_deq_o),
		.station_load_o   (station_load),
		.dispatch_count_o (issued_count_o)
	);

	// operands and tag are shared, only the load bit selects a station
	for (genvar s = 0; s < `NUM_STATIONS; s++) begin : g_station
		exec_station i_exec_station (
			.clk         (clk),
			.rst         (rst),
			.flush_i     (flush_o),
			.load_i      (station_load[s]),
			.op_i        (instr_op_i),
			.tag_i       (alloc_tag),
			.a_i         (instr_a_i),
			.b_i         (instr_b_i),
			.busy_o      (station_busy[s]),
			.done_o      (station_done[s]),
			.done_tag_o  (done_tag[s]),
			.done_data_o (done_data[s])
		);
	end

	reorder_buffer i_reorder_buffer (
		.clk              (clk),
		.rst              (rst),
		.enq_i            (instr_deq_o),
		.enq_pc_i         (instr_pc_i),
		.enq_target_i     (instr_target_i),
		.enq_rd_i         (instr_rd_i),
		.enq_is_branch_i  (is_branch),
		.enq_pred_taken_i (instr_pred_taken_i),
		.done_i           (station_done),
		.done_tag_i       (done_tag),
		.done_data_i      (done_data),
		.alloc_tag_o      (alloc_tag),
		.full_o           (rob_full),
		.commit_valid_o   (commit_valid_o),
		.commit_pc_o      (commit_pc_o),
		.commit_rd_o      (commit_rd_o),
		.commit_data_o    (commit_data_o),
		.flush_o          (flush_o),
		.flush_pc_o       (flush_pc_o)
	);

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module reorder_buffer (
	input  logic               clk,
	input  logic               rst,
	input  logic               enq_i,
	input  logic [`DATA_W-1:0] enq_pc_i,
	input  logic [`DATA_W-1:0] enq_target_i,
	input  logic [4:0]         enq_rd_i,
	input  logic               enq_is_branch_i,
	input  logic               enq_pred_taken_i,
	input  logic [`NUM_STATIONS-1:0] done_i,
	input  logic [`TAG_W-1:0]  done_tag_i [`NUM_STATIONS],
	input  logic [`DATA_W-1:0] done_data_i [`NUM_STATIONS],
	output logic [`TAG_W-1:0]  alloc_tag_o,
	output logic               full_o,
	output logic               commit_valid_o,
	output logic [`DATA_W-1:0] commit_pc_o,
	output logic [4:0]         commit_rd_o,
	output logic [`DATA_W-1:0] commit_data_o,
	output logic               flush_o,
	output logic [`DATA_W-1:0] flush_pc_o
);

	// per-entry state
	logic [`ROB_DEPTH-1:0] valid_q;
	logic [`ROB_DEPTH-1:0] ready_q;
	logic [`DATA_W-1:0]    data_q   [`ROB_DEPTH];
	logic [`DATA_W-1:0]    pc_q     [`ROB_DEPTH];
	logic [`DATA_W-1:0]    target_q [`ROB_DEPTH];
	logic [4:0]            rd_q     [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] br_q;
	logic [`ROB_DEPTH-1:0] pred_q;

	logic [`TAG_W-1:0]     head;
	logic [`TAG_W-1:0]     tail;
	logic [`TAG_W:0]       count;
	logic                  actual_taken;
	logic                  head_is_br;

	function automatic logic [`TAG_W-1:0] ptr_inc(input logic [`TAG_W-1:0] p);
		logic [`TAG_W-1:0] n;
		if (int'(p) == `ROB_DEPTH - 1) begin
			n = '0;
		end else begin
			n = p + 1'b1;
		end
		return n;
	endfunction

	assign alloc_tag_o = tail;
	assign full_o      = (count == (`TAG_W+1)'(`ROB_DEPTH));

	// head commits as soon as its result is in
	assign commit_valid_o = valid_q[head] && ready_q[head];
	assign head_is_br     = br_q[head];
	assign actual_taken   = data_q[head][0];

	assign commit_pc_o   = pc_q[head];
	assign commit_rd_o   = head_is_br ? 5'd0 : rd_q[head];
	assign commit_data_o = data_q[head];

	// branches resolve at commit, mispredict redirects fetch
	assign flush_o    = commit_valid_o && head_is_br && (actual_taken != pred_q[head]);
	assign flush_pc_o = actual_taken ? target_q[head] : pc_q[head] + `DATA_W'(4);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			ready_q <= '0;
			head    <= '0;
			tail    <= '0;
			count   <= '0;
		end else if (flush_o) begin
			// the mispredicted branch and everything younger go away
			valid_q <= '0;
			ready_q <= '0;
			head    <= '0;
			tail    <= '0;
			count   <= '0;
		end else begin
			for (int s = 0; s < `NUM_STATIONS; s++) begin
				if (done_i[s]) begin
					ready_q[done_tag_i[s]] <= 1'b1;
				end
			end
			if (enq_i) begin
				valid_q[tail] <= 1'b1;
				ready_q[tail] <= 1'b0;
				tail          <= ptr_inc(tail);
			end
			if (commit_valid_o) begin
				valid_q[head] <= 1'b0;
				ready_q[head] <= 1'b0;
				head          <= ptr_inc(head);
			end
			case ({enq_i, commit_valid_o})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// payload fields
	always_ff @(posedge clk) begin
		if (enq_i) begin
			pc_q[tail]     <= enq_pc_i;
			target_q[tail] <= enq_target_i;
			rd_q[tail]     <= enq_rd_i;
			br_q[tail]     <= enq_is_branch_i;
			pred_q[tail]   <= enq_pred_taken_i;
		end
		for (int s = 0; s < `NUM_STATIONS; s++) begin
			if (done_i[s]) begin
				data_q[done_tag_i[s]] <= done_data_i[s];
			end
		end
	end

endmodule

// File: design/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// reorder buffer entries, a power of two
`define ROB_DEPTH 8

// tag indexes one buffer entry
`define TAG_W 3

// identical execution stations
`define NUM_STATIONS 3

// operands, results and pc values
`define DATA_W 32

`endif

// File: design/rob_pkg.sv
package rob_pkg;

	// opcodes as they arrive from the instruction queue
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_mul = 3'd2,
		// branch compares, result is the taken bit
		op_beq = 3'd3,
		op_bne = 3'd4
	} op_t;

	// execution station FSM
	typedef enum logic [1:0] {
		// free, waiting for a load
		st_idle   = 2'd0,
		// add, sub and compares finish on the next edge
		st_single = 2'd1,
		// shift-and-add multiply, one byte of b per cycle
		st_mul    = 2'd2
	} station_state_t;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_ooo_core -f all.f -o sim_ooo_core \
	&& ./obj_dir/sim_ooo_core | tee /dev/stderr | grep -qx "TEST OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: test/ooo_model.svh
`ifndef OOO_MODEL_SVH
`define OOO_MODEL_SVH

// one accepted instruction with its expected result
typedef struct packed {
	logic [`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] target;
	logic [`DATA_W-1:0] result;
	logic [4:0]         rd;
	logic               branch;
	logic               pred;
} instr_rec_t;

// oldest first, front is the next to commit
instr_rec_t accepted_q[$];
int         squashed_total;

function automatic logic [`DATA_W-1:0] expected_result(input rob_pkg::op_t op,
		input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b);
	case (op)
		rob_pkg::op_add: return a + b;
		rob_pkg::op_sub: return a - b;
		// low word of the product
		rob_pkg::op_mul: return a * b;
		rob_pkg::op_beq: return `DATA_W'(a == b);
		rob_pkg::op_bne: return `DATA_W'(a != b);
		default:         return '0;
	endcase
endfunction

task automatic record_accept();
	instr_rec_t rec;
	rec.pc     = instr_pc_i;
	rec.target = instr_target_i;
	rec.result = expected_result(instr_op_i, instr_a_i, instr_b_i);
	rec.rd     = instr_rd_i;
	rec.branch = instr_op_i inside {rob_pkg::op_beq, rob_pkg::op_bne};
	rec.pred   = instr_pred_taken_i;
	accepted_q.push_back(rec);
endtask

task automatic check_commit();
	instr_rec_t rec;
	logic       mispredict;
	if (accepted_q.size() == 0) begin
		$display("%s: commit at pc %h with no instruction outstanding", test_name, commit_pc_o);
		test_errors++;
		return;
	end
	rec        = accepted_q.pop_front();
	mispredict = rec.branch && (rec.result[0] != rec.pred);
	check_value("commit pc", rec.pc, commit_pc_o);
	check_value("commit rd", rec.branch ? '0 : `DATA_W'(rec.rd), `DATA_W'(commit_rd_o));
	check_value("commit data", rec.result, commit_data_o);
	check_value("flush", `DATA_W'(mispredict), `DATA_W'(flush_o));
	if (mispredict) begin
		check_value("flush pc", rec.result[0] ? rec.target : rec.pc + `DATA_W'(4), flush_pc_o);
	end
	// whatever is still queued is younger than the flushing branch
	if (flush_o) begin
		flush_seen++;
		squashed_total += accepted_q.size();
		accepted_q.delete();
	end
endtask

`endif

// File: test/tb_ooo_core.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module tb_ooo_core;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_INSTR  = 400;
	localparam int TIMEOUT_NS = NUM_INSTR * 12 * CLK_PERIOD;

	logic               clk, rst, instr_valid_i, instr_pred_taken_i, pending;
	logic [`DATA_W-1:0] instr_pc_i, instr_a_i, instr_b_i, instr_target_i, next_pc;
	rob_pkg::op_t       instr_op_i;
	logic [4:0]         instr_rd_i, commit_rd_o;
	logic               instr_deq_o, commit_valid_o, flush_o;
	logic [`DATA_W-1:0] commit_pc_o, commit_data_o, flush_pc_o;
	logic [15:0]        issued_count_o;
	integer             seed;
	string              test_name;
	int                 checks, test_errors, errors, tests_failed, accepted_total, flush_seen;

	`include "ooo_model.svh"

	ooo_core i_ooo_core (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string what, input logic [`DATA_W-1:0] expected,
			input logic [`DATA_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// next instruction of the sequential stream
	task automatic new_instr(input int pct_branch, input int pct_mul, input bit correct_pred);
		int                 r;
		logic [`DATA_W-1:0] res;
		r          = rand_below(100);
		instr_a_i  = $random(seed);
		instr_b_i  = $random(seed);
		instr_op_i = rand_below(2) == 0 ? rob_pkg::op_add : rob_pkg::op_sub;
		if (r < pct_branch) begin
			instr_op_i = rand_below(2) == 0 ? rob_pkg::op_beq : rob_pkg::op_bne;
			// equal operands half the time, so both compares go either way
			if (rand_below(2) == 0) instr_b_i = instr_a_i;
		end else if (r < pct_branch + pct_mul) begin
			instr_op_i = rob_pkg::op_mul;
		end
		res                = expected_result(instr_op_i, instr_a_i, instr_b_i);
		instr_pc_i         = next_pc;
		instr_rd_i         = 5'($random(seed));
		instr_target_i     = $random(seed) & ~32'h3;
		instr_pred_taken_i = correct_pred ? res[0] : rand_below(2) == 1;
		next_pc            = next_pc + `DATA_W'(4);
		pending            = 1'b1;
	endtask

	task automatic run_test(input string name, input int count, input int pct_branch,
			input int pct_mul, input int pct_gap, input bit correct_pred);
		int taken;
		test_name   = name;
		checks      = 0;
		test_errors = 0;
		flush_seen  = 0;
		taken       = 0;
		while (taken < count || accepted_q.size() != 0) begin
			@(negedge clk);
			// commit outputs hold until the next rising edge
			if (commit_valid_o) check_commit();
			if (flush_o) begin
				pending = 1'b0;
				next_pc = flush_pc_o;
			end
			if (!pending && taken < count && rand_below(100) >= pct_gap) begin
				new_instr(pct_branch, pct_mul, correct_pred);
			end
			instr_valid_i = pending;
			// dequeue follows the inputs just driven
			#1;
			// no dequeue from an empty queue or during a flush
			if (!instr_valid_i || flush_o) begin
				check_value("held dequeue", '0, `DATA_W'(instr_deq_o));
			end
			if (instr_deq_o) begin
				record_accept();
				pending = 1'b0;
				taken++;
				accepted_total++;
			end
		end
		if (correct_pred) begin
			check_value("flush count", '0, `DATA_W'(flush_seen));
		end else begin
			check_value("any flush", `DATA_W'(1), `DATA_W'(flush_seen > 0));
		end
		check_value("issued count", `DATA_W'(accepted_total), `DATA_W'(issued_count_o));
		if (test_errors != 0) tests_failed++;
		errors += test_errors;
		$display("test %s: %s, %0d checks, %0d errors", name,
			test_errors == 0 ? "passed" : "failed", checks, test_errors);
	endtask

	initial begin
		seed       = 17;
		clk        = 1'b0;
		rst        = 1'b1;
		instr_op_i = rob_pkg::op_add;
		{instr_valid_i, instr_pred_taken_i, instr_rd_i, pending} = '0;
		{instr_pc_i, instr_a_i, instr_b_i, instr_target_i, next_pc} = '0;
		{errors, tests_failed, accepted_total, squashed_total} = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		// counts add up to NUM_INSTR
		run_test("alu_in_order", 60, 0, 0, 25, 1'b1);
		run_test("mul_out_of_order", 80, 0, 40, 10, 1'b1);
		run_test("branch_predicted", 60, 30, 20, 10, 1'b1);
		run_test("branch_mispredict", 100, 20, 20, 15, 1'b0);
		run_test("mul_backpressure", 100, 0, 100, 0, 1'b1);
		$display("summary: %0d of 5 tests failed, %0d errors, %0d accepted, %0d squashed",
			tests_failed, errors, accepted_total, squashed_total);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog allows about 12 cycles per instruction
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: run stopped after %0d ns with %0d instructions accepted",
			TIMEOUT_NS, accepted_total);
		$display("TEST FAILED");
		$finish;
	end

endmodule
